/* Makefile */
# Verilator build and run for the CLINT testbench

obj_dir/Vclint_tb: list.f $(wildcard hw/*.sv hw/*.svh sim/*.sv)
	verilator --binary --top-module clint_tb -f list.f -o Vclint_tb

.PHONY: run clean

run: obj_dir/Vclint_tb
	@out=$$(./obj_dir/Vclint_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

/* hw/clint_addr_decode.sv */
// CLINT command address decoder
`default_nettype none

`include "clint_defines.svh"

module clint_addr_decode
   import clint_pkg::*;
(
   input  logic                         rd_cmd_v_i,
   input  logic [`CLINT_ADDR_W-1:0]     rd_cmd_addr_i,
   input  logic                         wr_cmd_v_i,
   input  logic [`CLINT_ADDR_W-1:0]     wr_cmd_addr_i,
   output clint_sel_e                   rd_sel_o,
   output logic [`CLINT_CORE_IDX_W-1:0] rd_core_o,
   output clint_sel_e                   wr_sel_o,
   output logic [`CLINT_CORE_IDX_W-1:0] wr_core_o
);

   localparam int ADDR_W     = `CLINT_ADDR_W;
   localparam int REGION_W   = 4;
   // Registers are 64-bit aligned
   localparam int BYTE_OFS_W = 3;

   localparam logic [ADDR_W-1:0] MSIP_BASE     = `CLINT_MSIP_BASE;
   localparam logic [ADDR_W-1:0] MTIMECMP_BASE = `CLINT_MTIMECMP_BASE;
   localparam logic [ADDR_W-1:0] MEIP_BASE     = `CLINT_MEIP_BASE;
   localparam logic [ADDR_W-1:0] MTIME_ADDR    = `CLINT_MTIME_ADDR;
   localparam logic [ADDR_W-1:0] CFG_BASE      = `CLINT_CFG_BASE;

   function automatic clint_sel_e decode_region(input logic [ADDR_W-1:0] addr);
      logic [REGION_W-1:0] region;
      clint_sel_e          sel;
      region = addr[ADDR_W-1 -: REGION_W];
      sel    = e_sel_none;
      // mtime is matched on the full address
      if (addr == MTIME_ADDR) begin
         sel = e_sel_mtime;
      end else if (region == MSIP_BASE[ADDR_W-1 -: REGION_W]) begin
         sel = e_sel_msip;
      end else if (region == MTIMECMP_BASE[ADDR_W-1 -: REGION_W]) begin
         sel = e_sel_mtimecmp;
      end else if (region == MEIP_BASE[ADDR_W-1 -: REGION_W]) begin
         sel = e_sel_meip;
      end else if (region == CFG_BASE[ADDR_W-1 -: REGION_W]) begin
         sel = e_sel_cfg;
      end
      return sel;
   endfunction

   always_comb begin
      rd_sel_o = rd_cmd_v_i ? decode_region(rd_cmd_addr_i) : e_sel_none;
      wr_sel_o = wr_cmd_v_i ? decode_region(wr_cmd_addr_i) : e_sel_none;
   end

   assign rd_core_o = rd_cmd_addr_i[BYTE_OFS_W +: `CLINT_CORE_IDX_W];
   assign wr_core_o = wr_cmd_addr_i[BYTE_OFS_W +: `CLINT_CORE_IDX_W];

endmodule

`default_nettype wire

/* hw/clint_cfg_link.sv */
// CLINT configuration link
`default_nettype none

`include "clint_defines.svh"

module clint_cfg_link (
   input  logic                                          clk_i,
   input  logic                                          rst_n_i,
   input  logic                                          cfg_sel_v_i,
   input  logic [`CLINT_DWORD_W-1:0]                     wr_cmd_data_i,
   output logic [`CLINT_NUM_CORE-1:0]                    cfg_w_v_o,
   output logic [`CLINT_NUM_CORE-1:0][`CLINT_CFG_ADDR_W-1:0] cfg_addr_o,
   output logic [`CLINT_NUM_CORE-1:0][`CLINT_CFG_DATA_W-1:0] cfg_data_o
);

   localparam int NUM_CORE = `CLINT_NUM_CORE;
   localparam int ADDR_W   = `CLINT_CFG_ADDR_W;
   localparam int DATA_W   = `CLINT_CFG_DATA_W;
   localparam int CORE_W   = `CLINT_CFG_CORE_W;
   localparam int CFG_PIPE = `CLINT_CFG_PIPE;

   logic [CORE_W-1:0]   cfg_core;
   logic [NUM_CORE-1:0] cfg_strobe;

   // Stage layout is {strobe, addr, data}
   logic [CFG_PIPE-1:0][NUM_CORE+ADDR_W+DATA_W-1:0] cfg_pipe_r;

   assign cfg_core = wr_cmd_data_i[DATA_W+ADDR_W +: CORE_W];

   // All ones broadcasts, out-of-range cores get nothing
   always_comb begin
      for (int i = 0; i < NUM_CORE; i++) begin
         cfg_strobe[i] = cfg_sel_v_i & ((cfg_core == '1) || (cfg_core == CORE_W'(i)));
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cfg_pipe_r <= '0;
      end else begin
         cfg_pipe_r[0] <= {cfg_strobe, wr_cmd_data_i[0 +: ADDR_W+DATA_W]};
         for (int s = 1; s < CFG_PIPE; s++) begin
            cfg_pipe_r[s] <= cfg_pipe_r[s-1];
         end
      end
   end

   assign cfg_w_v_o = cfg_pipe_r[CFG_PIPE-1][ADDR_W+DATA_W +: NUM_CORE];

   for (genvar i = 0; i < NUM_CORE; i++) begin : g_core
      assign cfg_addr_o[i] = cfg_pipe_r[CFG_PIPE-1][DATA_W +: ADDR_W];
      assign cfg_data_o[i] = cfg_pipe_r[CFG_PIPE-1][0 +: DATA_W];
   end

endmodule

`default_nettype wire

/* hw/clint_defines.svh */
// CLINT configuration macros
`ifndef CLINT_DEFINES_SVH
`define CLINT_DEFINES_SVH

`define CLINT_NUM_CORE      4
`define CLINT_CORE_IDX_W    2
`define CLINT_ADDR_W        16
`define CLINT_DWORD_W       64
`define CLINT_TAG_W         8

// Region bases match on the top nibble, mtime on all bits
`define CLINT_MSIP_BASE     16'h0000
`define CLINT_MTIMECMP_BASE 16'h4000
`define CLINT_MEIP_BASE     16'h8000
`define CLINT_MTIME_ADDR    16'hBFF8
`define CLINT_CFG_BASE      16'hC000

`define CLINT_CFG_ADDR_W    16
`define CLINT_CFG_DATA_W    32
`define CLINT_CFG_CORE_W    3

`define CLINT_IRQ_PIPE      2
`define CLINT_CFG_PIPE      2

`endif

/* hw/clint_pkg.sv */
// CLINT shared types
`default_nettype none

`include "clint_defines.svh"

package clint_pkg;

   // Decoded register region of a command
   typedef enum logic [2:0] {
      e_sel_none,
      e_sel_msip,
      e_sel_mtimecmp,
      e_sel_meip,
      e_sel_mtime,
      e_sel_cfg
   } clint_sel_e;

   // Read response carries the data word back
   typedef struct packed {
      logic [`CLINT_TAG_W-1:0]   tag;
      logic [`CLINT_DWORD_W-1:0] data;
   } clint_rd_resp_s;

   // Write response is an acknowledge only
   typedef struct packed {
      logic [`CLINT_TAG_W-1:0] tag;
   } clint_wr_resp_s;

endpackage

`default_nettype wire

/* hw/clint_resp_buffer.sv */
// One-entry response buffer
`default_nettype none

module clint_resp_buffer #(
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  logic     v_i,
   input  payload_t data_i,
   output logic     ready_o,
   output logic     v_o,
   output payload_t data_o,
   input  logic     ready_i
);

   logic     full_r;
   payload_t data_r;

   // Accepts only while empty
   assign ready_o = ~full_r;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         full_r <= 1'b0;
      end else if (v_i && !full_r) begin
         full_r <= 1'b1;
      end else if (full_r && ready_i) begin
         full_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (v_i && !full_r) begin
         data_r <= data_i;
      end
   end

   assign v_o    = full_r;
   assign data_o = data_r;

endmodule

`default_nettype wire

/* hw/clint_timer_regs.sv */
// CLINT timer and interrupt registers
`default_nettype none

`include "clint_defines.svh"

module clint_timer_regs
   import clint_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   input  clint_sel_e                   rd_sel_i,
   input  logic [`CLINT_CORE_IDX_W-1:0] rd_core_i,
   input  clint_sel_e                   wr_sel_i,
   input  logic [`CLINT_CORE_IDX_W-1:0] wr_core_i,
   input  logic                         wr_accept_i,
   output logic [`CLINT_DWORD_W-1:0]    rd_data_o,
   input  logic [`CLINT_DWORD_W-1:0]    wr_data_i,
   output logic [`CLINT_NUM_CORE-1:0]   soft_irq_o,
   output logic [`CLINT_NUM_CORE-1:0]   timer_irq_o,
   output logic [`CLINT_NUM_CORE-1:0]   external_irq_o
);

   localparam int NUM_CORE = `CLINT_NUM_CORE;
   localparam int DWORD_W  = `CLINT_DWORD_W;
   localparam int IRQ_PIPE = `CLINT_IRQ_PIPE;

   logic [DWORD_W-1:0]               mtime_r;
   logic [NUM_CORE-1:0][DWORD_W-1:0] mtimecmp_r;
   logic [NUM_CORE-1:0]              msip_r;
   logic [NUM_CORE-1:0]              meip_r;
   logic [NUM_CORE-1:0]              timer_pend;

   // Stage layout is {meip, timer, msip}
   logic [IRQ_PIPE-1:0][3*NUM_CORE-1:0] irq_pipe_r;

   // Free-running timer, a write loads instead of counting
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         mtime_r <= '0;
      end else if (wr_accept_i && (wr_sel_i == e_sel_mtime)) begin
         mtime_r <= wr_data_i;
      end else begin
         mtime_r <= mtime_r + DWORD_W'(1);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         mtimecmp_r <= '1;
         msip_r     <= '0;
         meip_r     <= '0;
      end else if (wr_accept_i) begin
         case (wr_sel_i)
            e_sel_msip:     msip_r[wr_core_i]     <= wr_data_i[0];
            e_sel_mtimecmp: mtimecmp_r[wr_core_i] <= wr_data_i;
            e_sel_meip:     meip_r[wr_core_i]     <= wr_data_i[0];
            default: ;
         endcase
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_CORE; i++) begin
         timer_pend[i] = (mtime_r >= mtimecmp_r[i]);
      end
   end

   // Retiming toward the cores
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         irq_pipe_r <= '0;
      end else begin
         irq_pipe_r[0] <= {meip_r, timer_pend, msip_r};
         for (int s = 1; s < IRQ_PIPE; s++) begin
            irq_pipe_r[s] <= irq_pipe_r[s-1];
         end
      end
   end

   assign soft_irq_o     = irq_pipe_r[IRQ_PIPE-1][0 +: NUM_CORE];
   assign timer_irq_o    = irq_pipe_r[IRQ_PIPE-1][NUM_CORE +: NUM_CORE];
   assign external_irq_o = irq_pipe_r[IRQ_PIPE-1][2*NUM_CORE +: NUM_CORE];

   // Read mux, zero for unmapped and cfg
   always_comb begin
      case (rd_sel_i)
         e_sel_msip:     rd_data_o = {{(DWORD_W-1){1'b0}}, msip_r[rd_core_i]};
         e_sel_mtimecmp: rd_data_o = mtimecmp_r[rd_core_i];
         e_sel_meip:     rd_data_o = {{(DWORD_W-1){1'b0}}, meip_r[rd_core_i]};
         e_sel_mtime:    rd_data_o = mtime_r;
         default:        rd_data_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/clint_top.sv */
// CLINT top level
`default_nettype none

`include "clint_defines.svh"

module clint_top
   import clint_pkg::*;
(
   input  logic                                              clk_i,
   input  logic                                              rst_n_i,

   input  logic                                              rd_cmd_v_i,
   input  logic [`CLINT_ADDR_W-1:0]                          rd_cmd_addr_i,
   input  logic [`CLINT_TAG_W-1:0]                           rd_cmd_tag_i,
   output logic                                              rd_cmd_yumi_o,

   input  logic                                              wr_cmd_v_i,
   input  logic [`CLINT_ADDR_W-1:0]                          wr_cmd_addr_i,
   input  logic [`CLINT_DWORD_W-1:0]                         wr_cmd_data_i,
   input  logic [`CLINT_TAG_W-1:0]                           wr_cmd_tag_i,
   output logic                                              wr_cmd_yumi_o,

   output logic                                              rd_resp_v_o,
   output logic [`CLINT_TAG_W-1:0]                           rd_resp_tag_o,
   output logic [`CLINT_DWORD_W-1:0]                         rd_resp_data_o,
   input  logic                                              rd_resp_ready_i,

   output logic                                              wr_resp_v_o,
   output logic [`CLINT_TAG_W-1:0]                           wr_resp_tag_o,
   input  logic                                              wr_resp_ready_i,

   output logic [`CLINT_NUM_CORE-1:0]                        soft_irq_o,
   output logic [`CLINT_NUM_CORE-1:0]                        timer_irq_o,
   output logic [`CLINT_NUM_CORE-1:0]                        external_irq_o,

   output logic [`CLINT_NUM_CORE-1:0]                        cfg_w_v_o,
   output logic [`CLINT_NUM_CORE-1:0][`CLINT_CFG_ADDR_W-1:0] cfg_addr_o,
   output logic [`CLINT_NUM_CORE-1:0][`CLINT_CFG_DATA_W-1:0] cfg_data_o
);

   clint_sel_e                   rd_sel;
   clint_sel_e                   wr_sel;
   logic [`CLINT_CORE_IDX_W-1:0] rd_core;
   logic [`CLINT_CORE_IDX_W-1:0] wr_core;
   logic [`CLINT_DWORD_W-1:0]    rd_data;
   logic                         rd_buf_ready;
   logic                         wr_buf_ready;
   clint_rd_resp_s               rd_resp_d, rd_resp_q;
   clint_wr_resp_s               wr_resp_d, wr_resp_q;

   // Commands are taken only when their response slot is free
   assign rd_cmd_yumi_o = rd_cmd_v_i & rd_buf_ready;
   assign wr_cmd_yumi_o = wr_cmd_v_i & wr_buf_ready;

   clint_addr_decode u_addr_decode (
      .rd_cmd_v_i    (rd_cmd_v_i),
      .rd_cmd_addr_i (rd_cmd_addr_i),
      .wr_cmd_v_i    (wr_cmd_v_i),
      .wr_cmd_addr_i (wr_cmd_addr_i),
      .rd_sel_o      (rd_sel),
      .rd_core_o     (rd_core),
      .wr_sel_o      (wr_sel),
      .wr_core_o     (wr_core)
   );

   clint_timer_regs u_timer_regs (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .rd_sel_i       (rd_sel),
      .rd_core_i      (rd_core),
      .wr_sel_i       (wr_sel),
      .wr_core_i      (wr_core),
      .wr_accept_i    (wr_cmd_yumi_o),
      .rd_data_o      (rd_data),
      .wr_data_i      (wr_cmd_data_i),
      .soft_irq_o     (soft_irq_o),
      .timer_irq_o    (timer_irq_o),
      .external_irq_o (external_irq_o)
   );

   clint_cfg_link u_cfg_link (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_sel_v_i   (wr_cmd_yumi_o & (wr_sel == e_sel_cfg)),
      .wr_cmd_data_i (wr_cmd_data_i),
      .cfg_w_v_o     (cfg_w_v_o),
      .cfg_addr_o    (cfg_addr_o),
      .cfg_data_o    (cfg_data_o)
   );

   assign rd_resp_d = '{tag: rd_cmd_tag_i, data: rd_data};
   assign wr_resp_d = '{tag: wr_cmd_tag_i};

   clint_resp_buffer #(.payload_t(clint_rd_resp_s)) u_rd_resp_buffer (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (rd_cmd_yumi_o),
      .data_i  (rd_resp_d),
      .ready_o (rd_buf_ready),
      .v_o     (rd_resp_v_o),
      .data_o  (rd_resp_q),
      .ready_i (rd_resp_ready_i)
   );

   clint_resp_buffer #(.payload_t(clint_wr_resp_s)) u_wr_resp_buffer (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (wr_cmd_yumi_o),
      .data_i  (wr_resp_d),
      .ready_o (wr_buf_ready),
      .v_o     (wr_resp_v_o),
      .data_o  (wr_resp_q),
      .ready_i (wr_resp_ready_i)
   );

   assign rd_resp_tag_o  = rd_resp_q.tag;
   assign rd_resp_data_o = rd_resp_q.data;
   assign wr_resp_tag_o  = wr_resp_q.tag;

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/clint_pkg.sv
hw/clint_addr_decode.sv
hw/clint_timer_regs.sv
hw/clint_cfg_link.sv
hw/clint_resp_buffer.sv
hw/clint_top.sv
sim/clint_checker.sv
sim/clint_tb.sv

/* sim/clint_checker.sv */
// CLINT port checker
`default_nettype none

`include "clint_defines.svh"

module clint_checker
   import clint_pkg::*;
(
   input  logic                                              clk_i,
   input  logic                                              rst_n_i,
   input  logic                                              rd_cmd_v_i,
   input  logic [`CLINT_ADDR_W-1:0]                          rd_cmd_addr_i,
   input  logic [`CLINT_TAG_W-1:0]                           rd_cmd_tag_i,
   input  logic                                              rd_cmd_yumi_i,
   input  logic                                              wr_cmd_v_i,
   input  logic [`CLINT_ADDR_W-1:0]                          wr_cmd_addr_i,
   input  logic [`CLINT_DWORD_W-1:0]                         wr_cmd_data_i,
   input  logic [`CLINT_TAG_W-1:0]                           wr_cmd_tag_i,
   input  logic                                              wr_cmd_yumi_i,
   input  logic                                              rd_resp_v_i,
   input  logic [`CLINT_TAG_W-1:0]                           rd_resp_tag_i,
   input  logic [`CLINT_DWORD_W-1:0]                         rd_resp_data_i,
   input  logic                                              rd_resp_ready_i,
   input  logic                                              wr_resp_v_i,
   input  logic [`CLINT_TAG_W-1:0]                           wr_resp_tag_i,
   input  logic                                              wr_resp_ready_i,
   input  logic [`CLINT_NUM_CORE-1:0]                        soft_irq_i,
   input  logic [`CLINT_NUM_CORE-1:0]                        timer_irq_i,
   input  logic [`CLINT_NUM_CORE-1:0]                        external_irq_i,
   input  logic [`CLINT_NUM_CORE-1:0]                        cfg_w_v_i,
   input  logic [`CLINT_NUM_CORE-1:0][`CLINT_CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [`CLINT_NUM_CORE-1:0][`CLINT_CFG_DATA_W-1:0] cfg_data_i,
   input  logic [`CLINT_DWORD_W-1:0]                         exp_rd_data_i,
   input  logic                                              exp_rd_chk_i,
   output int                                                errors_o
);

   localparam int NC = `CLINT_NUM_CORE;
   localparam int IP = `CLINT_IRQ_PIPE;
   localparam int CP = `CLINT_CFG_PIPE;

   // Shadow registers for the cycle being observed
   logic [63:0]   mtime;
   logic [63:0]   mtimecmp [NC];
   logic [NC-1:0] msip;
   logic [NC-1:0] meip;
   logic [NC-1:0] soft_p [IP];
   logic [NC-1:0] timer_p [IP];
   logic [NC-1:0] ext_p [IP];
   logic [NC-1:0] cfg_v_p [CP];
   logic [15:0]   cfg_a_p [CP];
   logic [31:0]   cfg_d_p [CP];

   // Pending responses as {tag, data} and tag
   logic [71:0]   rd_q [$];
   logic [7:0]    wr_q [$];
   // Table expectation per pending read as {check, data}
   logic [64:0]   tab_q [$];
   logic          rd_acc;
   logic          wr_acc;
   clint_sel_e    wsel;
   logic [2:0]    cfg_core;
   int            errors = 0;

   assign errors_o = errors;

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("Checker failure at %0t: %s", $time, what);
      errors++;
   endtask

   function automatic clint_sel_e region_of(input logic [15:0] addr);
      if (addr == `CLINT_MTIME_ADDR) begin
         return e_sel_mtime;
      end
      case (addr[15:12])
         4'h0:    return e_sel_msip;
         4'h4:    return e_sel_mtimecmp;
         4'h8:    return e_sel_meip;
         4'hC:    return e_sel_cfg;
         default: return e_sel_none;
      endcase
   endfunction

   function automatic logic [63:0] read_value(input logic [15:0] addr);
      logic [1:0] core;
      core = addr[4:3];
      case (region_of(addr))
         e_sel_msip:     return 64'(msip[core]);
         e_sel_meip:     return 64'(meip[core]);
         e_sel_mtimecmp: return mtimecmp[core];
         e_sel_mtime:    return mtime;
         default:        return '0;
      endcase
   endfunction

   task automatic check_ports();
      if (soft_irq_i !== soft_p[IP-1])
         report_mismatch("soft_irq_o", 64'(soft_irq_i), 64'(soft_p[IP-1]));
      if (timer_irq_i !== timer_p[IP-1])
         report_mismatch("timer_irq_o", 64'(timer_irq_i), 64'(timer_p[IP-1]));
      if (external_irq_i !== ext_p[IP-1])
         report_mismatch("external_irq_o", 64'(external_irq_i), 64'(ext_p[IP-1]));
      if (cfg_w_v_i !== cfg_v_p[CP-1])
         report_mismatch("cfg_w_v_o", 64'(cfg_w_v_i), 64'(cfg_v_p[CP-1]));
      for (int i = 0; i < NC; i++) begin
         if (cfg_v_p[CP-1][i] && (cfg_addr_i[i] !== cfg_a_p[CP-1]))
            report_mismatch("cfg_addr_o", 64'(cfg_addr_i[i]), 64'(cfg_a_p[CP-1]));
         if (cfg_v_p[CP-1][i] && (cfg_data_i[i] !== cfg_d_p[CP-1]))
            report_mismatch("cfg_data_o", 64'(cfg_data_i[i]), 64'(cfg_d_p[CP-1]));
      end
      if (rd_cmd_yumi_i && (!rd_cmd_v_i || rd_resp_v_i))
         report_failure("read yumi raised without a valid or while the buffer is full");
      if (wr_cmd_yumi_i && (!wr_cmd_v_i || wr_resp_v_i))
         report_failure("write yumi raised without a valid or while the buffer is full");
      if (rd_resp_v_i && rd_q.size() == 0) begin
         report_failure("read response with no read pending");
      end else if (!rd_resp_v_i && rd_q.size() != 0) begin
         report_failure("read response missing for an accepted read");
      end else if (rd_resp_v_i) begin
         if (rd_resp_tag_i !== rd_q[0][71:64])
            report_mismatch("rd_resp_tag_o", 64'(rd_resp_tag_i), 64'(rd_q[0][71:64]));
         if (rd_resp_data_i !== rd_q[0][63:0])
            report_mismatch("rd_resp_data_o", rd_resp_data_i, rd_q[0][63:0]);
         if (tab_q[0][64] && (rd_resp_data_i !== tab_q[0][63:0]))
            report_mismatch("rd_resp_data_o", rd_resp_data_i, tab_q[0][63:0]);
         if (rd_resp_ready_i) begin
            void'(rd_q.pop_front());
            void'(tab_q.pop_front());
         end
      end
      if (wr_resp_v_i && wr_q.size() == 0) begin
         report_failure("write response with no write pending");
      end else if (!wr_resp_v_i && wr_q.size() != 0) begin
         report_failure("write response missing for an accepted write");
      end else if (wr_resp_v_i) begin
         if (wr_resp_tag_i !== wr_q[0])
            report_mismatch("wr_resp_tag_o", 64'(wr_resp_tag_i), 64'(wr_q[0]));
         if (wr_resp_ready_i)
            void'(wr_q.pop_front());
      end
   endtask

   // Steps the model across the coming clock edge
   task automatic advance_model();
      rd_acc = rd_cmd_v_i && rd_cmd_yumi_i;
      wr_acc = wr_cmd_v_i && wr_cmd_yumi_i;
      wsel   = wr_acc ? region_of(wr_cmd_addr_i) : e_sel_none;
      if (rd_acc) begin
         rd_q.push_back({rd_cmd_tag_i, read_value(rd_cmd_addr_i)});
         tab_q.push_back({exp_rd_chk_i, exp_rd_data_i});
      end
      if (wr_acc)
         wr_q.push_back(wr_cmd_tag_i);
      for (int s = IP - 1; s > 0; s--) begin
         soft_p[s]  = soft_p[s-1];
         timer_p[s] = timer_p[s-1];
         ext_p[s]   = ext_p[s-1];
      end
      soft_p[0] = msip;
      ext_p[0]  = meip;
      for (int i = 0; i < NC; i++) begin
         timer_p[0][i] = (mtime >= mtimecmp[i]);
      end
      for (int s = CP - 1; s > 0; s--) begin
         cfg_v_p[s] = cfg_v_p[s-1];
         cfg_a_p[s] = cfg_a_p[s-1];
         cfg_d_p[s] = cfg_d_p[s-1];
      end
      // Core field 7 is broadcast
      cfg_core = wr_cmd_data_i[50:48];
      for (int i = 0; i < NC; i++) begin
         cfg_v_p[0][i] = (wsel == e_sel_cfg) && (cfg_core == 3'b111 || cfg_core == 3'(i));
      end
      cfg_a_p[0] = wr_cmd_data_i[47:32];
      cfg_d_p[0] = wr_cmd_data_i[31:0];
      mtime = (wsel == e_sel_mtime) ? wr_cmd_data_i : mtime + 64'd1;
      case (wsel)
         e_sel_msip:     msip[wr_cmd_addr_i[4:3]] = wr_cmd_data_i[0];
         e_sel_meip:     meip[wr_cmd_addr_i[4:3]] = wr_cmd_data_i[0];
         e_sel_mtimecmp: mtimecmp[wr_cmd_addr_i[4:3]] = wr_cmd_data_i;
         default: ;
      endcase
   endtask

   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         mtime = '0;
         msip  = '0;
         meip  = '0;
         for (int i = 0; i < NC; i++) begin
            mtimecmp[i] = '1;
         end
         for (int s = 0; s < IP; s++) begin
            soft_p[s]  = '0;
            timer_p[s] = '0;
            ext_p[s]   = '0;
         end
         for (int s = 0; s < CP; s++) begin
            cfg_v_p[s] = '0;
            cfg_a_p[s] = '0;
            cfg_d_p[s] = '0;
         end
         rd_q.delete();
         wr_q.delete();
         tab_q.delete();
      end else begin
         check_ports();
         advance_model();
      end
   end

endmodule

`default_nettype wire

/* sim/clint_tb.sv */
// CLINT testbench
`default_nettype none

`include "clint_defines.svh"

module clint_tb;

   localparam int OP_RD   = 0;
   localparam int OP_WR   = 1;
   localparam int OP_RW   = 2;
   localparam int OP_IDLE = 3;
   localparam int MAX_ENT = 64;

   logic                                              clk = 1'b0;
   logic                                              rst_n;
   logic                                              rd_cmd_v;
   logic [`CLINT_ADDR_W-1:0]                          rd_cmd_addr;
   logic [`CLINT_TAG_W-1:0]                           rd_cmd_tag;
   logic                                              rd_cmd_yumi;
   logic                                              wr_cmd_v;
   logic [`CLINT_ADDR_W-1:0]                          wr_cmd_addr;
   logic [`CLINT_DWORD_W-1:0]                         wr_cmd_data;
   logic [`CLINT_TAG_W-1:0]                           wr_cmd_tag;
   logic                                              wr_cmd_yumi;
   logic                                              rd_resp_v;
   logic [`CLINT_TAG_W-1:0]                           rd_resp_tag;
   logic [`CLINT_DWORD_W-1:0]                         rd_resp_data;
   logic                                              rd_resp_ready;
   logic                                              wr_resp_v;
   logic [`CLINT_TAG_W-1:0]                           wr_resp_tag;
   logic                                              wr_resp_ready;
   logic [`CLINT_NUM_CORE-1:0]                        soft_irq;
   logic [`CLINT_NUM_CORE-1:0]                        timer_irq;
   logic [`CLINT_NUM_CORE-1:0]                        external_irq;
   logic [`CLINT_NUM_CORE-1:0]                        cfg_w_v;
   logic [`CLINT_NUM_CORE-1:0][`CLINT_CFG_ADDR_W-1:0] cfg_addr;
   logic [`CLINT_NUM_CORE-1:0][`CLINT_CFG_DATA_W-1:0] cfg_data;
   logic [`CLINT_DWORD_W-1:0]                         exp_rd_data;
   logic                                              exp_rd_chk;

   // Stimulus table of operation, address, data or idle count and expected read
   int          op_tab [MAX_ENT];
   logic [15:0] addr_tab [MAX_ENT];
   logic [63:0] data_tab [MAX_ENT];
   logic [63:0] exp_tab [MAX_ENT];
   bit          chk_tab [MAX_ENT];
   int          n_ent = 0;
   int          table_len = 0;
   int          chk_errors;
   integer      seed = 32;
   integer      rnd;

   always #5 clk = ~clk;

   clint_top u_clint_top (
      .clk_i (clk), .rst_n_i (rst_n),
      .rd_cmd_v_i (rd_cmd_v), .rd_cmd_addr_i (rd_cmd_addr),
      .rd_cmd_tag_i (rd_cmd_tag), .rd_cmd_yumi_o (rd_cmd_yumi),
      .wr_cmd_v_i (wr_cmd_v), .wr_cmd_addr_i (wr_cmd_addr), .wr_cmd_data_i (wr_cmd_data),
      .wr_cmd_tag_i (wr_cmd_tag), .wr_cmd_yumi_o (wr_cmd_yumi),
      .rd_resp_v_o (rd_resp_v), .rd_resp_tag_o (rd_resp_tag),
      .rd_resp_data_o (rd_resp_data), .rd_resp_ready_i (rd_resp_ready),
      .wr_resp_v_o (wr_resp_v), .wr_resp_tag_o (wr_resp_tag), .wr_resp_ready_i (wr_resp_ready),
      .soft_irq_o (soft_irq), .timer_irq_o (timer_irq), .external_irq_o (external_irq),
      .cfg_w_v_o (cfg_w_v), .cfg_addr_o (cfg_addr), .cfg_data_o (cfg_data)
   );

   clint_checker u_checker (
      .clk_i (clk), .rst_n_i (rst_n),
      .rd_cmd_v_i (rd_cmd_v), .rd_cmd_addr_i (rd_cmd_addr),
      .rd_cmd_tag_i (rd_cmd_tag), .rd_cmd_yumi_i (rd_cmd_yumi),
      .wr_cmd_v_i (wr_cmd_v), .wr_cmd_addr_i (wr_cmd_addr), .wr_cmd_data_i (wr_cmd_data),
      .wr_cmd_tag_i (wr_cmd_tag), .wr_cmd_yumi_i (wr_cmd_yumi),
      .rd_resp_v_i (rd_resp_v), .rd_resp_tag_i (rd_resp_tag),
      .rd_resp_data_i (rd_resp_data), .rd_resp_ready_i (rd_resp_ready),
      .wr_resp_v_i (wr_resp_v), .wr_resp_tag_i (wr_resp_tag), .wr_resp_ready_i (wr_resp_ready),
      .soft_irq_i (soft_irq), .timer_irq_i (timer_irq), .external_irq_i (external_irq),
      .cfg_w_v_i (cfg_w_v), .cfg_addr_i (cfg_addr), .cfg_data_i (cfg_data),
      .exp_rd_data_i (exp_rd_data), .exp_rd_chk_i (exp_rd_chk),
      .errors_o (chk_errors)
   );

   task automatic add_entry(input int op, input logic [15:0] addr, input logic [63:0] data,
                            input logic [63:0] exp, input bit chk);
      op_tab[n_ent]   = op;
      addr_tab[n_ent] = addr;
      data_tab[n_ent] = data;
      exp_tab[n_ent]  = exp;
      chk_tab[n_ent]  = chk;
      n_ent++;
   endtask

   task automatic load_table();
      logic [15:0] ofs;
      logic [63:0] cmp;
      for (int c = 0; c < `CLINT_NUM_CORE; c++) begin
         ofs = 16'(c * 8);
         // Core 0 gets a compare value that mtime soon passes
         cmp = (c == 0) ? 64'h40 : {32'hA5A5_0000, 32'(c)};
         add_entry(OP_WR, `CLINT_MSIP_BASE + ofs, 64'h1, 64'h0, 1'b0);
         add_entry(OP_WR, `CLINT_MEIP_BASE + ofs, 64'(c % 2), 64'h0, 1'b0);
         add_entry(OP_WR, `CLINT_MTIMECMP_BASE + ofs, cmp, 64'h0, 1'b0);
         add_entry(OP_RD, `CLINT_MSIP_BASE + ofs, 64'h0, 64'h1, 1'b1);
         add_entry(OP_RD, `CLINT_MEIP_BASE + ofs, 64'h0, 64'(c % 2), 1'b1);
         add_entry(OP_RD, `CLINT_MTIMECMP_BASE + ofs, 64'h0, cmp, 1'b1);
      end
      add_entry(OP_RD, 16'h2008, 64'h0, 64'h0, 1'b1);
      add_entry(OP_RD, 16'hC000, 64'h0, 64'h0, 1'b1);
      add_entry(OP_WR, 16'hF000, 64'hDEAD, 64'h0, 1'b0);
      add_entry(OP_RD, 16'hF000, 64'h0, 64'h0, 1'b1);
      add_entry(OP_RD, `CLINT_MTIME_ADDR, 64'h0, 64'h0, 1'b0);
      add_entry(OP_WR, 16'h4010, 64'h1020, 64'h0, 1'b0);
      add_entry(OP_WR, `CLINT_MTIME_ADDR, 64'h1000, 64'h0, 1'b0);
      add_entry(OP_IDLE, 16'h0, 64'd50, 64'h0, 1'b0);
      add_entry(OP_RD, `CLINT_MTIME_ADDR, 64'h0, 64'h0, 1'b0);
      add_entry(OP_WR, 16'hC000, 64'h0001_1234_DEAD_BEEF, 64'h0, 1'b0);
      add_entry(OP_WR, 16'hC008, 64'h0007_ABCD_0123_4567, 64'h0, 1'b0);
      add_entry(OP_WR, 16'hC000, 64'h0004_4444_0000_0004, 64'h0, 1'b0);
      add_entry(OP_WR, 16'hC000, 64'h0005_5555_0000_0005, 64'h0, 1'b0);
      add_entry(OP_WR, 16'hC000, 64'h0006_6666_0000_0006, 64'h0, 1'b0);
      add_entry(OP_IDLE, 16'h0, 64'd5, 64'h0, 1'b0);
      add_entry(OP_RW, 16'h4000, 64'hFFFF_0000_0000_0000, 64'h40, 1'b1);
      add_entry(OP_RD, 16'h4000, 64'h0, 64'hFFFF_0000_0000_0000, 1'b1);
      add_entry(OP_RW, 16'h0010, 64'h0, 64'h1, 1'b1);
      add_entry(OP_RD, 16'h0010, 64'h0, 64'h0, 1'b1);
      add_entry(OP_WR, 16'h0008, 64'h0, 64'h0, 1'b0);
      add_entry(OP_IDLE, 16'h0, 64'd5, 64'h0, 1'b0);
   endtask

   // Holds each command until its yumi is seen at the falling edge
   task automatic drive_cmd(input bit do_rd, input bit do_wr, input logic [15:0] addr,
                            input logic [63:0] data, input logic [7:0] tag,
                            input logic [63:0] exp, input bit chk);
      bit rd_pend;
      bit wr_pend;
      bit rd_take;
      bit wr_take;
      rd_pend = do_rd;
      wr_pend = do_wr;
      if (do_rd) begin
         rd_cmd_v    = 1'b1;
         rd_cmd_addr = addr;
         rd_cmd_tag  = tag;
         exp_rd_data = exp;
         exp_rd_chk  = chk;
      end
      if (do_wr) begin
         wr_cmd_v    = 1'b1;
         wr_cmd_addr = addr;
         wr_cmd_data = data;
         wr_cmd_tag  = tag;
      end
      while (rd_pend || wr_pend) begin
         @(negedge clk);
         rd_take = rd_cmd_v && rd_cmd_yumi;
         wr_take = wr_cmd_v && wr_cmd_yumi;
         @(posedge clk);
         #1;
         if (rd_take) begin
            rd_pend  = 1'b0;
            rd_cmd_v = 1'b0;
         end
         if (wr_take) begin
            wr_pend  = 1'b0;
            wr_cmd_v = 1'b0;
         end
      end
   endtask

   task automatic wait_resp_empty();
      while (rd_resp_v || wr_resp_v) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic idle_cycles(input logic [7:0] n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Random response back-pressure
   initial begin
      rd_resp_ready = 1'b0;
      wr_resp_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         rnd           = $random(seed);
         rd_resp_ready = rnd[0];
         wr_resp_ready = rnd[1];
      end
   end

   initial begin
      wait (table_len > 0);
      repeat (table_len * 40 + 200) @(posedge clk);
      $display("Watchdog expired before the stimulus table completed");
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      logic [7:0] tag;
      rst_n       = 1'b0;
      rd_cmd_v    = 1'b0;
      rd_cmd_addr = '0;
      rd_cmd_tag  = '0;
      wr_cmd_v    = 1'b0;
      wr_cmd_addr = '0;
      wr_cmd_data = '0;
      wr_cmd_tag  = '0;
      exp_rd_data = '0;
      exp_rd_chk  = 1'b0;
      load_table();
      table_len = n_ent;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int n = 0; n < table_len; n++) begin
         tag = 8'(n + 1);
         case (op_tab[n])
            OP_RD: drive_cmd(1'b1, 1'b0, addr_tab[n], data_tab[n], tag, exp_tab[n], chk_tab[n]);
            OP_WR: drive_cmd(1'b0, 1'b1, addr_tab[n], data_tab[n], tag, exp_tab[n], chk_tab[n]);
            OP_RW: begin
               // Both buffers empty so the two commands are taken together
               wait_resp_empty();
               drive_cmd(1'b1, 1'b1, addr_tab[n], data_tab[n], tag, exp_tab[n], chk_tab[n]);
            end
            default: idle_cycles(data_tab[n][7:0]);
         endcase
      end
      wait_resp_empty();
      idle_cycles(8'd10);
      $display("Run complete: %0d errors", chk_errors);
      if (chk_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
